//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sdr_ctrl_top.f --top-module sdr_ctrl_tb \
   -o sdr_ctrl_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sdr_ctrl_sim > sim.log 2>&1 || echo "simulator returned an error"

grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 || \
   { cat sim.log; echo "simulation failed"; exit 1; }

//--- sdr_ctrl_top.f
verilog/sdr_ctrl_pkg.sv
verilog/sdr_sel_if.sv
verilog/sdr_req_queue.sv
verilog/sdr_port_arbiter.sv
verilog/sdr_cmd_fsm.sv
verilog/sdr_data_path.sv
verilog/sdr_ctrl_top.sv
test/sdr_mem_model.sv
test/sdr_ctrl_tb.sv

//--- test/sdr_ctrl_tb.sv
`timescale 1ns/100ps

module sdr_ctrl_tb;
   import sdr_ctrl_pkg::*;

   logic                                sdram_clk;
   logic                                sdram_rst;
   logic [NR_PORTS-1:0]                 wb_stb_i;
   logic [NR_PORTS-1:0]                 wb_we_i;
   logic [NR_PORTS-1:0][ADR_W-1:0]      wb_adr_i;
   logic [NR_PORTS-1:0][DAT_W-1:0]      wb_dat_i;
   logic [NR_PORTS-1:0][SEL_W-1:0]      wb_sel_i;
   logic [NR_PORTS-1:0]                 wb_stall_o;
   logic [NR_PORTS-1:0]                 wb_ack_o;
   logic [NR_PORTS-1:0][DAT_W-1:0]      wb_dat_o;
   logic                                cs_n, cke, ras, cas, we;
   logic [BA_W-1:0]                     ba;
   logic [ROW_W-1:0]                    a;
   logic [DQ_W-1:0]                     dq_o, dq_i;
   logic                                dq_oe;
   logic [1:0]                          dqm;
   int                                  ref_cnt, bad_ref_cnt;
   logic                                mode_seen;

   logic [31:0] lfsr;
   logic [31:0] ref_mem [bit [ADR_W-1:0]];
   logic [32:0] exp0 [$];
   logic [32:0] exp1 [$];
   int          val_errs, other_errs, cyc, first_ack, init_n;
   logic        saw_stall;
   logic        wr_prev;
   sdr_cmd_e    init_cmd [4];
   logic [ROW_W-1:0] init_a [4];

   sdr_ctrl_top dut0 (
      .sdram_clk(sdram_clk), .sdram_rst(sdram_rst),
      .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_stall_o(wb_stall_o),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .cs_n_pad_o(cs_n), .cke_pad_o(cke), .ras_pad_o(ras), .cas_pad_o(cas),
      .we_pad_o(we), .ba_pad_o(ba), .a_pad_o(a), .dq_o(dq_o), .dq_i(dq_i),
      .dq_oe_o(dq_oe), .dqm_pad_o(dqm)
   );

   sdr_mem_model mem0 (
      .sdram_clk(sdram_clk), .cs_n_i(cs_n), .ras_i(ras), .cas_i(cas), .we_i(we),
      .ba_i(ba), .a_i(a), .dq_i(dq_o), .dqm_i(dqm), .dq_o(dq_i),
      .ref_cnt_o(ref_cnt), .bad_ref_cnt_o(bad_ref_cnt), .mode_seen_o(mode_seen)
   );

   always #4 sdram_clk = ~sdram_clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         val_errs++;
      end
   endtask

   // update the reference on acceptance and queue what the ack must carry
   task automatic record(input int p, input logic w, input logic [ADR_W-1:0] adr,
                         input logic [31:0] dat, input logic [3:0] s);
      logic [31:0] old;
      logic [32:0] entry;
      old   = ref_mem.exists(adr) ? ref_mem[adr] : 32'h0;
      entry = {1'b0, old};
      if (w) begin
         for (int b = 0; b < 4; b++)
            if (s[b])
               old[8*b +: 8] = dat[8*b +: 8];
         ref_mem[adr] = old;
         entry        = {1'b1, 32'h0};
      end
      if (p == 0)
         exp0.push_back(entry);
      else
         exp1.push_back(entry);
   endtask

   // small address space per port with the port index in the low column bit
   task automatic present(input int p, input int we_mode, input bit full_sel);
      logic            w;
      logic [ADR_W-1:0] adr;
      logic [31:0]     dat;
      logic [3:0]      s;
      w   = (we_mode == 2) ? 1'(rand_bits(1)) : we_mode[0];
      adr = {2'(rand_bits(2)), 11'd0, 2'(rand_bits(2)), 5'd0, 2'(rand_bits(2)), 1'(p)};
      dat = rand_bits(32);
      s   = full_sel ? 4'hf : 4'(rand_bits(4));
      wb_stb_i[p] = 1'b1;
      wb_we_i[p]  = w;
      wb_adr_i[p] = adr;
      wb_dat_i[p] = dat;
      wb_sel_i[p] = s;
      if (wb_stall_o[p])
         saw_stall = 1'b1;
      else
         record(p, w, adr, dat, s);
   endtask

   task automatic run_traffic(input int cycles, input logic [1:0] ports, input int we_mode,
                              input bit full_sel, input int sparse);
      repeat (cycles) begin
         @(negedge sdram_clk);
         wb_stb_i = '0;
         for (int p = 0; p < NR_PORTS; p++)
            if (ports[p] && rand_bits(sparse) == 0)
               present(p, we_mode, full_sel);
      end
      @(negedge sdram_clk);
      wb_stb_i = '0;
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (exp0.size() + exp1.size() != 0 && n < limit) begin
         @(negedge sdram_clk);
         n++;
      end
      if (exp0.size() + exp1.size() != 0) begin
         $display("timeout: %0d acks never arrived", exp0.size() + exp1.size());
         other_errs++;
      end
   endtask

   // monitor for reset outputs, pad controls, init order and acks
   always @(negedge sdram_clk) begin
      logic [32:0] e;
      logic        wr_now;
      wr_now = ({ras, cas, we} == 3'(WRITE));
      if (sdram_rst) begin
         check("reset cmd", 32'(NOP), 32'({ras, cas, we}));
         check("reset stall", 32'd0, 32'(wb_stall_o));
         check("reset ack", 32'd0, 32'(wb_ack_o));
         check("reset dq_oe", 32'd0, 32'(dq_oe));
      end else begin
         cyc++;
         if (cyc > 1) begin
            check("cs_n", 32'd0, 32'(cs_n));
            check("cke", 32'd1, 32'(cke));
         end
         // dq is driven on the WRITE cycle and the beat after it
         check("dq_oe", 32'(wr_now || wr_prev), 32'(dq_oe));
         if (!(wr_now || wr_prev))
            check("dqm idle", 32'd0, 32'(dqm));
         if ({ras, cas, we} != 3'(NOP) && init_n < 4) begin
            init_cmd[init_n] = sdr_cmd_e'({ras, cas, we});
            init_a[init_n]   = a;
            init_n++;
         end
         for (int p = 0; p < NR_PORTS; p++) begin
            if (wb_ack_o[p]) begin
               if (first_ack < 0)
                  first_ack = p;
               if ((p == 0 && exp0.size() == 0) || (p == 1 && exp1.size() == 0)) begin
                  $display("ack on port %0d with no request outstanding", p);
                  other_errs++;
               end else begin
                  e = (p == 0) ? exp0.pop_front() : exp1.pop_front();
                  if (!e[32])
                     check($sformatf("read data port %0d", p), e[31:0], wb_dat_o[p]);
               end
            end
         end
      end
      wr_prev = wr_now;
   end

   initial begin
      int n;
      sdram_clk = 1'b0;
      sdram_rst = 1'b1;
      wb_stb_i  = '0;
      wb_we_i   = '0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      wb_sel_i  = '0;
      lfsr      = 32'hc5b7ec81;
      val_errs  = 0;
      other_errs = 0;
      cyc       = 0;
      init_n    = 0;
      first_ack = -1;
      saw_stall = 1'b0;
      wr_prev   = 1'b0;
      repeat (16) @(negedge sdram_clk);
      sdram_rst = 1'b0;

      // a request waiting during init must not start an access early
      @(negedge sdram_clk);
      present(0, 1, 1'b1);
      @(negedge sdram_clk);
      wb_stb_i = '0;

      n = 0;
      while (!mode_seen && n < 200) begin
         @(negedge sdram_clk);
         n++;
      end
      if (!mode_seen) begin
         $display("timeout: init sequence never issued LOAD_MODE");
         other_errs++;
      end
      check("init cmd 0", 32'(PRECHARGE), 32'(init_cmd[0]));
      check("init a10", 32'd1, 32'(init_a[0][10]));
      check("init cmd 1", 32'(REFRESH), 32'(init_cmd[1]));
      check("init cmd 2", 32'(REFRESH), 32'(init_cmd[2]));
      check("init cmd 3", 32'(LOAD_MODE), 32'(init_cmd[3]));
      check("mode word", 32'(MODE_VALUE), 32'(init_a[3]));

      // full-word writes and then reads back
      run_traffic(40, 2'b01, 1, 1'b1, 0);
      wait_drain(2000);
      run_traffic(40, 2'b01, 0, 1'b1, 0);
      wait_drain(2000);

      // byte selects on port 1
      run_traffic(60, 2'b10, 2, 1'b0, 1);
      wait_drain(2000);

      // both ports start on the same cycle
      first_ack = -1;
      run_traffic(30, 2'b11, 2, 1'b0, 0);
      wait_drain(3000);
      check("first ack port", 32'd0, 32'(first_ack));

      saw_stall = 1'b0;
      run_traffic(30, 2'b10, 1, 1'b1, 0);
      wait_drain(2000);
      check("stall seen", 32'd1, 32'(saw_stall));

      // long mixed run for refresh
      run_traffic(1500, 2'b11, 2, 1'b0, 2);
      wait_drain(3000);
      check("refresh rate ok", 32'd1, 32'((ref_cnt - 2) >= cyc / REF_PERIOD - 1));
      check("refresh while active", 32'd0, 32'(bad_ref_cnt));

      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

//--- test/sdr_mem_model.sv
`timescale 1ns/100ps

module sdr_mem_model (
   input  logic                            sdram_clk,
   input  logic                            cs_n_i,
   input  logic                            ras_i,
   input  logic                            cas_i,
   input  logic                            we_i,
   input  logic [sdr_ctrl_pkg::BA_W-1:0]   ba_i,
   input  logic [sdr_ctrl_pkg::ROW_W-1:0]  a_i,
   input  logic [sdr_ctrl_pkg::DQ_W-1:0]   dq_i,
   input  logic [1:0]                      dqm_i,
   output logic [sdr_ctrl_pkg::DQ_W-1:0]   dq_o,
   output int                              ref_cnt_o,
   output int                              bad_ref_cnt_o,
   output logic                            mode_seen_o
);
   import sdr_ctrl_pkg::*;

   logic [DQ_W-1:0]  cells [bit [23:0]];
   logic [ROW_W-1:0] open_row [4];
   logic [3:0]       bank_open;
   logic             v1, v2, v3;
   logic             wr_pend;
   logic [23:0]      a1, a2, a3, wr_key;
   sdr_cmd_e         cmd;

   function automatic logic [DQ_W-1:0] masked(input logic [DQ_W-1:0] old,
                                             input logic [DQ_W-1:0] val,
                                             input logic [1:0] m);
      logic [DQ_W-1:0] r;
      r = old;
      if (!m[1])
         r[15:8] = val[15:8];
      if (!m[0])
         r[7:0] = val[7:0];
      return r;
   endfunction

   function automatic logic [DQ_W-1:0] cell_at(input logic [23:0] k);
      return cells.exists(k) ? cells[k] : '0;
   endfunction

   initial begin
      dq_o          = '0;
      ref_cnt_o     = 0;
      bad_ref_cnt_o = 0;
      mode_seen_o   = 1'b0;
      bank_open     = '0;
      {v1, v2, v3}  = 3'b000;
      wr_pend       = 1'b0;
   end

   // commands are stable mid-cycle; read beats leave CAS_LAT cycles later
   always @(negedge sdram_clk) begin
      cmd = cs_n_i ? NOP : sdr_cmd_e'({ras_i, cas_i, we_i});
      if (v2)
         dq_o = cell_at(a2);
      else if (v3)
         dq_o = cell_at(a3 | 24'd1);
      v3 = v2;
      a3 = a2;
      v2 = v1;
      a2 = a1;
      v1 = 1'b0;
      // second write beat goes to the odd column
      if (wr_pend)
         cells[wr_key | 24'd1] = masked(cell_at(wr_key | 24'd1), dq_i, dqm_i);
      wr_pend = 1'b0;
      case (cmd)
         ACTIVE: begin
            open_row[ba_i]  = a_i;
            bank_open[ba_i] = 1'b1;
         end
         READ, WRITE: begin
            a1 = {ba_i, open_row[ba_i], a_i[8:0]};
            if (cmd == READ) begin
               v1 = 1'b1;
            end else begin
               cells[a1] = masked(cell_at(a1), dq_i, dqm_i);
               wr_key    = a1;
               wr_pend   = 1'b1;
            end
            if (a_i[10])
               bank_open[ba_i] = 1'b0;
         end
         PRECHARGE: bank_open = a_i[10] ? 4'b0 : (bank_open & ~(4'b1 << ba_i));
         REFRESH: begin
            ref_cnt_o++;
            if (bank_open != 0)
               bad_ref_cnt_o++;
         end
         LOAD_MODE: mode_seen_o = 1'b1;
         default: ;
      endcase
   end

endmodule

//--- verilog/sdr_cmd_fsm.sv
`timescale 1ns/100ps

module sdr_cmd_fsm (
   input  logic                             sdram_clk,
   input  logic                             sdram_rst,
   sdr_sel_if.fsm                           sel,
   output sdr_ctrl_pkg::sdr_cmd_e           cmd_o,
   output logic [sdr_ctrl_pkg::BA_W-1:0]    ba_o,
   output logic [sdr_ctrl_pkg::ROW_W-1:0]   a_o,
   output logic                             cs_n_o,
   output logic                             cke_o
);
   import sdr_ctrl_pkg::*;

   typedef enum logic [3:0] {
      S_PWR,
      S_INIT_RP,
      S_INIT_RFC1,
      S_INIT_RFC2,
      S_MRD,
      S_IDLE,
      S_RFC,
      S_RCD,
      S_PRE_WAIT
   } state_e;

   state_e               state;
   logic [CNT_W-1:0]     cnt;
   logic                 cnt_done;
   logic [REF_CNT_W-1:0] ref_cnt;
   logic                 refresh_req;
   logic                 issue_ref;
   logic                 issue_rw;
   logic [PORT_W-1:0]    port_q;

   assign cnt_done  = (cnt == '0);
   assign issue_ref = (state == S_IDLE) && refresh_req;
   assign issue_rw  = (state == S_RCD) && cnt_done;

   // strobes lead the pad command by one cycle
   assign sel.take      = (state == S_IDLE) && !refresh_req && sel.sel_valid;
   assign sel.cmd_read  = issue_rw && !sel.sel_req.we;
   assign sel.cmd_write = issue_rw && sel.sel_req.we;
   assign sel.cmd_port  = port_q;

   // refresh timer with a request that stays set until a REFRESH goes out
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt     <= REF_CNT_W'(REF_PERIOD - 1);
         refresh_req <= 1'b0;
      end else begin
         if (ref_cnt == '0)
            ref_cnt <= REF_CNT_W'(REF_PERIOD - 1);
         else
            ref_cnt <= ref_cnt - 1'b1;
         if (ref_cnt == '0)
            refresh_req <= 1'b1;
         else if (issue_ref)
            refresh_req <= 1'b0;
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state  <= S_PWR;
         cnt    <= CNT_W'(INIT_WAIT - 1);
         cmd_o  <= NOP;
         ba_o   <= '0;
         a_o    <= '0;
         port_q <= '0;
         cs_n_o <= 1'b1;
         cke_o  <= 1'b0;
      end else begin
         cs_n_o <= 1'b0;
         cke_o  <= 1'b1;
         cmd_o  <= NOP;
         if (!cnt_done)
            cnt <= cnt - 1'b1;
         case (state)
            // power-up wait and then precharge all
            S_PWR: begin
               if (cnt_done) begin
                  cmd_o <= PRECHARGE;
                  a_o   <= AP_MASK;
                  cnt   <= CNT_W'(T_RP - 1);
                  state <= S_INIT_RP;
               end
            end
            S_INIT_RP: begin
               if (cnt_done) begin
                  cmd_o <= REFRESH;
                  cnt   <= CNT_W'(T_RFC - 1);
                  state <= S_INIT_RFC1;
               end
            end
            S_INIT_RFC1: begin
               if (cnt_done) begin
                  cmd_o <= REFRESH;
                  cnt   <= CNT_W'(T_RFC - 1);
                  state <= S_INIT_RFC2;
               end
            end
            S_INIT_RFC2: begin
               if (cnt_done) begin
                  cmd_o <= LOAD_MODE;
                  ba_o  <= '0;
                  a_o   <= MODE_VALUE;
                  cnt   <= CNT_W'(T_RP - 1);
                  state <= S_MRD;
               end
            end
            S_MRD, S_RFC, S_PRE_WAIT: begin
               if (cnt_done)
                  state <= S_IDLE;
            end
            // refresh goes ahead of a new access
            S_IDLE: begin
               if (issue_ref) begin
                  cmd_o <= REFRESH;
                  cnt   <= CNT_W'(T_RFC - 1);
                  state <= S_RFC;
               end else if (sel.take) begin
                  cmd_o  <= ACTIVE;
                  ba_o   <= sel.sel_req.adr[ADR_W-1 -: BA_W];
                  a_o    <= sel.sel_req.adr[ADR_W-BA_W-1 -: ROW_W];
                  port_q <= sel.sel_port;
                  cnt    <= CNT_W'(T_RCD - 1);
                  state  <= S_RCD;
               end
            end
            // column access with auto-precharge and the beat bit at zero
            S_RCD: begin
               if (cnt_done) begin
                  cmd_o <= sel.sel_req.we ? WRITE : READ;
                  a_o   <= AP_MASK | ROW_W'({sel.sel_req.adr[COL_W-2:0], 1'b0});
                  cnt   <= CNT_W'(T_WR + T_RP - 1);
                  state <= S_PRE_WAIT;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // a pending refresh waits for at most the access in progress
   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      refresh_req |-> !$past(refresh_req, T_RCD + T_WR + T_RP + 2));

endmodule

//--- verilog/sdr_ctrl_pkg.sv
package sdr_ctrl_pkg;

   // port and queue sizing
   localparam int NR_PORTS    = 2;
   localparam int PORT_W      = $clog2(NR_PORTS);
   localparam int QUEUE_DEPTH = 2;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

   // word address is {bank, row, column without the beat bit}
   localparam int ADR_W = 23;
   localparam int BA_W  = 2;
   localparam int ROW_W = 13;
   localparam int COL_W = 9;
   localparam int DQ_W  = 16;
   localparam int DAT_W = 32;
   localparam int SEL_W = 4;

   // timing in sdram_clk cycles
   localparam int CAS_LAT    = 2;
   localparam int INIT_WAIT  = 20;
   localparam int T_RP       = 2;
   localparam int T_RCD      = 2;
   localparam int T_RFC      = 7;
   localparam int T_WR       = 2;
   localparam int REF_PERIOD = 390;
   localparam int READ_LAT   = CAS_LAT + 2;
   localparam int CNT_W      = $clog2(INIT_WAIT + 1);
   localparam int REF_CNT_W  = $clog2(REF_PERIOD);

   // a10 selects auto-precharge and precharge-all
   localparam logic [ROW_W-1:0] AP_MASK = ROW_W'(1) << 10;
   // burst length 2, sequential, cas latency 2
   localparam logic [ROW_W-1:0] MODE_VALUE = 13'h021;

   // {ras, cas, we}, active low on the pads
   typedef enum logic [2:0] {
      LOAD_MODE = 3'b000,
      REFRESH   = 3'b001,
      PRECHARGE = 3'b010,
      ACTIVE    = 3'b011,
      WRITE     = 3'b100,
      READ      = 3'b101,
      NOP       = 3'b111
   } sdr_cmd_e;

   typedef struct packed {
      logic             we;
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
      logic [SEL_W-1:0] sel;
   } sdr_req_t;

endpackage

//--- verilog/sdr_ctrl_top.sv
`timescale 1ns/100ps

module sdr_ctrl_top (
   input  logic                                                       sdram_clk,
   input  logic                                                       sdram_rst,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0]                          wb_stb_i,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0]                          wb_we_i,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0][sdr_ctrl_pkg::ADR_W-1:0] wb_adr_i,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0][sdr_ctrl_pkg::DAT_W-1:0] wb_dat_i,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0][sdr_ctrl_pkg::SEL_W-1:0] wb_sel_i,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0]                          wb_stall_o,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0]                          wb_ack_o,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0][sdr_ctrl_pkg::DAT_W-1:0] wb_dat_o,
   output logic                                                       cs_n_pad_o,
   output logic                                                       cke_pad_o,
   output logic                                                       ras_pad_o,
   output logic                                                       cas_pad_o,
   output logic                                                       we_pad_o,
   output logic [sdr_ctrl_pkg::BA_W-1:0]                              ba_pad_o,
   output logic [sdr_ctrl_pkg::ROW_W-1:0]                             a_pad_o,
   output logic [sdr_ctrl_pkg::DQ_W-1:0]                              dq_o,
   input  logic [sdr_ctrl_pkg::DQ_W-1:0]                              dq_i,
   output logic                                                       dq_oe_o,
   output logic [sdr_ctrl_pkg::SEL_W/2-1:0]                           dqm_pad_o
);
   import sdr_ctrl_pkg::*;

   logic [NR_PORTS-1:0]     q_empty;
   logic [NR_PORTS-1:0]     q_pop;
   sdr_req_t [NR_PORTS-1:0] q_head;
   sdr_cmd_e                pad_cmd;

   sdr_sel_if sel_bus ();

   // one request queue per port
   for (genvar i = 0; i < NR_PORTS; i++) begin : g_port
      sdr_req_queue u_queue (
         .sdram_clk  (sdram_clk),
         .sdram_rst  (sdram_rst),
         .wb_stb_i   (wb_stb_i[i]),
         .req_i      ({wb_we_i[i], wb_adr_i[i], wb_dat_i[i], wb_sel_i[i]}),
         .pop_i      (q_pop[i]),
         .wb_stall_o (wb_stall_o[i]),
         .empty_o    (q_empty[i]),
         .head_o     (q_head[i])
      );
   end

   sdr_port_arbiter u_arbiter (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .empty_i   (q_empty),
      .head_i    (q_head),
      .pop_o     (q_pop),
      .sel       (sel_bus.arb)
   );

   sdr_cmd_fsm u_fsm (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .sel       (sel_bus.fsm),
      .cmd_o     (pad_cmd),
      .ba_o      (ba_pad_o),
      .a_o       (a_pad_o),
      .cs_n_o    (cs_n_pad_o),
      .cke_o     (cke_pad_o)
   );

   sdr_data_path u_data_path (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .sel       (sel_bus.dp),
      .dq_o      (dq_o),
      .dq_i      (dq_i),
      .dq_oe_o   (dq_oe_o),
      .dqm_pad_o (dqm_pad_o),
      .wb_ack_o  (wb_ack_o),
      .wb_dat_o  (wb_dat_o)
   );

   assign {ras_pad_o, cas_pad_o, we_pad_o} = pad_cmd;

endmodule

//--- verilog/sdr_data_path.sv
`timescale 1ns/100ps

module sdr_data_path (
   input  logic                                                   sdram_clk,
   input  logic                                                   sdram_rst,
   sdr_sel_if.dp                                                  sel,
   output logic [sdr_ctrl_pkg::DQ_W-1:0]                          dq_o,
   input  logic [sdr_ctrl_pkg::DQ_W-1:0]                          dq_i,
   output logic                                                   dq_oe_o,
   output logic [sdr_ctrl_pkg::SEL_W/2-1:0]                       dqm_pad_o,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0]                      wb_ack_o,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0][sdr_ctrl_pkg::DAT_W-1:0] wb_dat_o
);
   import sdr_ctrl_pkg::*;

   logic [DQ_W-1:0]     beat_q;
   logic [SEL_W/2-1:0]  mask_q;
   logic                beat2_q;
   logic                wr_done_q;
   logic [PORT_W-1:0]   wr_port_q;
   logic [DQ_W-1:0]     dq_i_reg;
   logic [DQ_W-1:0]     dq_i_tmp;
   logic [READ_LAT-1:0] rd_vld;
   logic [PORT_W-1:0]   rd_port [READ_LAT];

   // write control: dq enable and byte masks over both beats
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         beat2_q   <= 1'b0;
         wr_done_q <= 1'b0;
         dq_oe_o   <= 1'b0;
         dqm_pad_o <= '0;
      end else begin
         beat2_q   <= sel.cmd_write;
         wr_done_q <= beat2_q;
         dq_oe_o   <= sel.cmd_write || beat2_q;
         if (sel.cmd_write)
            dqm_pad_o <= ~sel.sel_req.sel[SEL_W-1:SEL_W/2];
         else if (beat2_q)
            dqm_pad_o <= mask_q;
         else
            dqm_pad_o <= '0;
      end
   end

   // high half goes out first, low half is parked for the next cycle
   always_ff @(posedge sdram_clk) begin
      if (sel.cmd_write) begin
         dq_o      <= sel.sel_req.dat[DAT_W-1:DQ_W];
         beat_q    <= sel.sel_req.dat[DQ_W-1:0];
         mask_q    <= ~sel.sel_req.sel[SEL_W/2-1:0];
         wr_port_q <= sel.cmd_port;
      end else if (beat2_q) begin
         dq_o <= beat_q;
      end
   end

   // input registers and the read return line
   always_ff @(posedge sdram_clk) begin
      dq_i_reg   <= dq_i;
      dq_i_tmp   <= dq_i_reg;
      rd_port[0] <= sel.cmd_port;
      for (int k = 1; k < READ_LAT; k++)
         rd_port[k] <= rd_port[k-1];
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         rd_vld   <= '0;
         wb_ack_o <= '0;
      end else begin
         rd_vld <= {rd_vld[READ_LAT-2:0], sel.cmd_read};
         for (int p = 0; p < NR_PORTS; p++) begin
            wb_ack_o[p] <= (rd_vld[READ_LAT-1] && rd_port[READ_LAT-1] == PORT_W'(p)) ||
                           (wr_done_q && wr_port_q == PORT_W'(p));
         end
      end
   end

   // first beat is the high half; valid on the ack cycle
   assign wb_dat_o = {NR_PORTS{dq_i_tmp, dq_i_reg}};

endmodule

//--- verilog/sdr_port_arbiter.sv
`timescale 1ns/100ps

module sdr_port_arbiter (
   input  logic                                            sdram_clk,
   input  logic                                            sdram_rst,
   input  logic [sdr_ctrl_pkg::NR_PORTS-1:0]               empty_i,
   input  sdr_ctrl_pkg::sdr_req_t [sdr_ctrl_pkg::NR_PORTS-1:0] head_i,
   output logic [sdr_ctrl_pkg::NR_PORTS-1:0]               pop_o,
   sdr_sel_if.arb                                          sel
);
   import sdr_ctrl_pkg::*;

   logic [PORT_W-1:0] pick;
   logic              held_q;
   sdr_req_t          req_q;

   // lowest index wins
   always_comb begin
      pick = '0;
      for (int p = NR_PORTS - 1; p >= 0; p--) begin
         if (!empty_i[p])
            pick = PORT_W'(p);
      end
   end

   // selection frozen from take until the read or write command
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         sel.sel_valid <= 1'b0;
         sel.sel_port  <= '0;
         held_q        <= 1'b0;
      end else if (sel.take) begin
         held_q        <= 1'b1;
         sel.sel_valid <= 1'b0;
      end else if (sel.cmd_read || sel.cmd_write) begin
         held_q <= 1'b0;
      end else if (!held_q) begin
         sel.sel_valid <= |(~empty_i);
         sel.sel_port  <= pick;
      end
   end

   // the queue pops on take, so keep a copy of its head
   always_ff @(posedge sdram_clk) begin
      if (sel.take)
         req_q <= head_i[sel.sel_port];
   end

   assign sel.sel_req = held_q ? req_q : head_i[sel.sel_port];
   assign pop_o       = sel.take ? (NR_PORTS'(1) << sel.sel_port) : '0;

   // a take pops a non-empty queue and never lands while a request is held
   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      sel.take |-> !held_q && !empty_i[sel.sel_port]);

endmodule

//--- verilog/sdr_req_queue.sv
`timescale 1ns/100ps

module sdr_req_queue (
   input  logic                   sdram_clk,
   input  logic                   sdram_rst,
   input  logic                   wb_stb_i,
   input  sdr_ctrl_pkg::sdr_req_t req_i,
   input  logic                   pop_i,
   output logic                   wb_stall_o,
   output logic                   empty_o,
   output sdr_ctrl_pkg::sdr_req_t head_o
);
   import sdr_ctrl_pkg::*;

   sdr_req_t          mem [QUEUE_DEPTH];
   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;
   logic              push;

   function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
      return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // strobes seen while full are dropped
   assign push       = wb_stb_i && !wb_stall_o;
   assign wb_stall_o = (count == QCNT_W'(QUEUE_DEPTH));
   assign empty_o    = (count == '0);
   assign head_o     = mem[rd_ptr];

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop_i)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + QCNT_W'(push) - QCNT_W'(pop_i);
      end
   end

   always_ff @(posedge sdram_clk) begin
      if (push)
         mem[wr_ptr] <= req_i;
   end

   // the arbiter only pops a queue it saw non-empty
   assert property (@(posedge sdram_clk) disable iff (sdram_rst) pop_i |-> !empty_o);

endmodule

//--- verilog/sdr_sel_if.sv
`timescale 1ns/100ps

interface sdr_sel_if;
   import sdr_ctrl_pkg::*;

   // selected request, owned by the arbiter
   logic              sel_valid;
   logic [PORT_W-1:0] sel_port;
   sdr_req_t          sel_req;

   // strobes from the command FSM
   logic              take;
   logic              cmd_read;
   logic              cmd_write;
   logic [PORT_W-1:0] cmd_port;

   modport arb (
      output sel_valid, sel_port, sel_req,
      input  take, cmd_read, cmd_write
   );

   modport fsm (
      input  sel_valid, sel_port, sel_req,
      output take, cmd_read, cmd_write, cmd_port
   );

   modport dp (
      input  sel_req, cmd_read, cmd_write, cmd_port
   );

endinterface
